/* hw/approx_fp_pkg.sv */
`default_nettype none

package approx_fp_pkg;

  // IEEE single precision field widths
  parameter int EXP_W  = 8;
  parameter int FRAC_W = 23;

  // hidden bit, stored fraction and two guard bits below it
  parameter int SIG_W = 26;

  parameter int EXP_BIAS = 127;

  // all-ones exponent, used here only to encode infinity on overflow
  parameter int EXP_MAX = 255;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
  } fp32_fields_t;

  // the same float word either as raw bits or split into its fields
  typedef union packed {
    logic [EXP_W+FRAC_W:0] raw;
    fp32_fields_t          f;
  } fp32_u;

endpackage

`default_nettype wire

/* hw/loa_adder.sv */
`default_nettype none

// lower-part OR adder
// the low LPL bits are approximated by OR, the rest is added exactly
module loa_adder #(
  parameter int W   = 16,
  parameter int LPL = 8
) (
  input  logic [W-1:0] in1,
  input  logic [W-1:0] in2,
  output logic [W:0]   res
);

  logic             carry_in;
  logic [W-LPL:0]   upper_sum;

  // no carry chain in the approximate part
  assign res[LPL-1:0] = in1[LPL-1:0] | in2[LPL-1:0];

  // the top approximate bit position still predicts a carry into the exact part
  assign carry_in = in1[LPL-1] & in2[LPL-1];

  assign upper_sum = {1'b0, in1[W-1:LPL]}
                   + {1'b0, in2[W-1:LPL]}
                   + {{(W-LPL){1'b0}}, carry_in};

  // top bit of upper_sum lands on res[W] as the carry-out
  assign res[W:LPL] = upper_sum;

endmodule

`default_nettype wire

/* hw/significand_adder.sv */
`default_nettype none

// significand add/subtract with an approximate low part
// LPL of 0 falls back to a plain exact adder/subtractor
module significand_adder #(
  parameter int W         = 26,
  parameter int LOW_WIDTH = 16,
  parameter int LPL       = 8
) (
  input  logic         add_sub,
  input  logic [W-1:0] in1,
  input  logic [W-1:0] in2,
  output logic [W:0]   res
);

  generate
    if (LPL == 0) begin : g_exact

      assign res = add_sub ? ({1'b0, in1} - {1'b0, in2})
                           : ({1'b0, in1} + {1'b0, in2});

    end else begin : g_loa

      logic [W-1:0]           in2_signed;
      logic [LOW_WIDTH-1:0]   lower_res;
      logic                   approx_cout;
      logic [W-LOW_WIDTH:0]   upper_res;

      // one's complement only, the missing +1 is part of the approximation
      assign in2_signed = add_sub ? ~in2 : in2;

      loa_adder #(
        .W   (LOW_WIDTH),
        .LPL (LPL)
      ) loa_adder_inst (
        .in1 (in1[LOW_WIDTH-1:0]),
        .in2 (in2_signed[LOW_WIDTH-1:0]),
        .res ({approx_cout, lower_res})
      );

      assign upper_res = {1'b0, in1[W-1:LOW_WIDTH]}
                       + {1'b0, in2_signed[W-1:LOW_WIDTH]}
                       + {{(W-LOW_WIDTH){1'b0}}, approx_cout};

      assign res = {upper_res, lower_res};

    end
  endgenerate

endmodule

`default_nettype wire

/* hw/fp_align.sv */
`default_nettype none

// stage 1: unpack both operands, pick the larger magnitude and align the other one
module fp_align
  import approx_fp_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic [EXP_W+FRAC_W:0] op_a,
  input  logic [EXP_W+FRAC_W:0] op_b,
  input  logic                  op_sub,
  output logic                  al_valid,
  output logic                  al_sign,
  output logic [EXP_W-1:0]      al_exp,
  output logic                  al_sub,
  output logic [SIG_W-1:0]      al_sig_big,
  output logic [SIG_W-1:0]      al_sig_small
);

  fp32_u            a_u;
  fp32_u            b_u;
  logic [SIG_W-1:0] sig_a;
  logic [SIG_W-1:0] sig_b;
  logic             a_big;
  logic [EXP_W-1:0] exp_big;
  logic [EXP_W-1:0] exp_small;
  logic [EXP_W-1:0] exp_diff;
  logic [SIG_W-1:0] sig_big;
  logic [SIG_W-1:0] sig_small;
  logic [SIG_W-1:0] sig_small_sh;
  logic             eff_sub;
  logic             res_sign;

  assign a_u.raw = op_a;
  assign b_u.raw = op_b;

  // an exponent of 0 reads as zero, whatever the fraction holds
  assign sig_a = (a_u.f.exp == '0) ? '0 : {1'b1, a_u.f.frac, 2'b00};
  assign sig_b = (b_u.f.exp == '0) ? '0 : {1'b1, b_u.f.frac, 2'b00};

  // exponent and fraction compare as one unsigned magnitude, a wins a tie
  assign a_big = {a_u.f.exp, a_u.f.frac} >= {b_u.f.exp, b_u.f.frac};

  assign exp_big   = a_big ? a_u.f.exp : b_u.f.exp;
  assign exp_small = a_big ? b_u.f.exp : a_u.f.exp;
  assign sig_big   = a_big ? sig_a : sig_b;
  assign sig_small = a_big ? sig_b : sig_a;
  assign exp_diff  = exp_big - exp_small;

  // shifted-out bits are simply dropped
  assign sig_small_sh = (exp_diff >= SIG_W) ? '0 : (sig_small >> exp_diff);

  assign eff_sub = a_u.f.sign ^ b_u.f.sign ^ op_sub;

  // when b is the big one in a - b, its sign flips
  assign res_sign = a_big ? a_u.f.sign : (b_u.f.sign ^ op_sub);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      al_valid <= 1'b0;
    end else begin
      al_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    al_sign      <= res_sign;
    al_exp       <= exp_big;
    al_sub       <= eff_sub;
    al_sig_big   <= sig_big;
    al_sig_small <= sig_small_sh;
  end

  // the subtraction downstream relies on never borrowing past the top bit
  a_big_not_smaller : assert property (
    @(posedge clk) disable iff (!rst_n)
    al_valid |-> (al_sig_big >= al_sig_small)
  );

endmodule

`default_nettype wire

/* hw/fp_normalize.sv */
`default_nettype none

// stage 2 registers the raw sum, stage 3 normalizes, range-checks and packs
module fp_normalize
  import approx_fp_pkg::*;
#(
  parameter int W = 26
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  al_valid,
  input  logic                  al_sign,
  input  logic [EXP_W-1:0]      al_exp,
  input  logic                  al_sub,
  input  logic [W:0]            sum,
  output logic                  out_valid,
  output logic [EXP_W+FRAC_W:0] result
);

  localparam int LZC_W = $clog2(W + 1);

  logic             s2_valid;
  logic             s2_sign;
  logic [EXP_W-1:0] s2_exp;
  logic             s2_sub;
  logic [W:0]       s2_sum;

  logic [LZC_W-1:0] lzc;
  logic [EXP_W:0]   lzc_ext;
  logic [W-1:0]     norm_sig;
  logic [EXP_W:0]   norm_exp;
  logic             is_zero;
  fp32_u            pack_u;
  fp32_u            out_u;

  function automatic logic [LZC_W-1:0] count_lz(input logic [W-1:0] v);
    logic [LZC_W-1:0] n;
    logic             done;
    n    = '0;
    done = 1'b0;
    for (int i = W - 1; i >= 0; i--) begin
      if (v[i]) begin
        done = 1'b1;
      end else if (!done) begin
        n = n + 1'b1;
      end
    end
    return n;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s2_valid  <= al_valid;
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_sign <= al_sign;
    s2_exp  <= al_exp;
    s2_sub  <= al_sub;
    s2_sum  <= sum;
    result  <= pack_u.raw;
  end

  // the carry bit of a subtraction is ignored, only the low W bits count
  assign lzc     = count_lz(s2_sum[W-1:0]);
  assign lzc_ext = {{(EXP_W+1-LZC_W){1'b0}}, lzc};

  always_comb begin
    norm_sig = s2_sum[W-1:0];
    norm_exp = {1'b0, s2_exp};
    is_zero  = 1'b0;
    if (!s2_sub) begin
      if (s2_sum[W]) begin
        norm_sig = s2_sum[W:1];
        norm_exp = {1'b0, s2_exp} + 1'b1;
      end
    end else if ((s2_sum[W-1:0] == '0) || ({1'b0, s2_exp} <= lzc_ext)) begin
      // exact cancellation or underflow, flushed to +0
      is_zero = 1'b1;
    end else begin
      norm_sig = s2_sum[W-1:0] << lzc;
      norm_exp = {1'b0, s2_exp} - lzc_ext;
    end
  end

  always_comb begin
    pack_u.raw = '0;
    if (!is_zero) begin
      pack_u.f.sign = s2_sign;
      if (norm_exp >= EXP_MAX) begin
        pack_u.f.exp = EXP_W'(EXP_MAX);
      end else begin
        pack_u.f.exp  = norm_exp[EXP_W-1:0];
        // drop the hidden bit, truncate the guard bits
        pack_u.f.frac = norm_sig[W-2 -: FRAC_W];
      end
    end
  end

  assign out_u.raw = result;

  out_valid_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(out_valid)
  );

  // a packed fraction without an exponent would mean a denormal leaked out
  no_denormal_out : assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && (out_u.f.frac != '0)) |-> (out_u.f.exp != '0)
  );

endmodule

`default_nettype wire

/* hw/approx_fp_adder.sv */
`default_nettype none

// three-stage single-precision adder/subtractor with an LOA significand path
module approx_fp_adder
  import approx_fp_pkg::*;
#(
  parameter int LOW_WIDTH = 16,
  parameter int LPL       = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic [EXP_W+FRAC_W:0] op_a,
  input  logic [EXP_W+FRAC_W:0] op_b,
  input  logic                  op_sub,
  output logic                  out_valid,
  output logic [EXP_W+FRAC_W:0] result
);

  logic             al_valid;
  logic             al_sign;
  logic [EXP_W-1:0] al_exp;
  logic             al_sub;
  logic [SIG_W-1:0] al_sig_big;
  logic [SIG_W-1:0] al_sig_small;
  logic [SIG_W:0]   sum;

  fp_align fp_align_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .op_a         (op_a),
    .op_b         (op_b),
    .op_sub       (op_sub),
    .al_valid     (al_valid),
    .al_sign      (al_sign),
    .al_exp       (al_exp),
    .al_sub       (al_sub),
    .al_sig_big   (al_sig_big),
    .al_sig_small (al_sig_small)
  );

  // combinational, sits between the stage 1 and stage 2 registers
  significand_adder #(
    .W         (SIG_W),
    .LOW_WIDTH (LOW_WIDTH),
    .LPL       (LPL)
  ) significand_adder_inst (
    .add_sub (al_sub),
    .in1     (al_sig_big),
    .in2     (al_sig_small),
    .res     (sum)
  );

  fp_normalize #(
    .W (SIG_W)
  ) fp_normalize_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .al_valid  (al_valid),
    .al_sign   (al_sign),
    .al_exp    (al_exp),
    .al_sub    (al_sub),
    .sum       (sum),
    .out_valid (out_valid),
    .result    (result)
  );

endmodule

`default_nettype wire

/* tests/fp_model.svh */
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// 26-bit working significand: hidden bit, 23 fraction bits, two zero guard bits
function automatic logic [25:0] working_significand(input logic [31:0] w);
  if (w[30:23] == 8'd0) begin
    return 26'd0;
  end
  return {1'b1, w[22:0], 2'b00};
endfunction

// significand add or subtract, with the low lpl bits approximated by OR
function automatic logic [26:0] loa_sig_sum(input logic [25:0] sig_big,
                                            input logic [25:0] sig_small,
                                            input logic sub, input int lpl);
  logic [25:0] addend;
  logic [26:0] r;
  logic        c;
  if (lpl == 0) begin
    if (sub) begin
      return {1'b0, sig_big} - {1'b0, sig_small};
    end
    return {1'b0, sig_big} + {1'b0, sig_small};
  end
  // x - y is taken as x + ~y, without the extra one
  addend = sub ? ~sig_small : sig_small;
  r      = '0;
  for (int i = 0; i < lpl; i++) begin
    r[i] = sig_big[i] | addend[i];
  end
  c = sig_big[lpl-1] & addend[lpl-1];
  // ripple carry through every bit above the OR part
  for (int i = lpl; i < 26; i++) begin
    r[i] = sig_big[i] ^ addend[i] ^ c;
    c    = (sig_big[i] & addend[i]) | (c & (sig_big[i] ^ addend[i]));
  end
  r[26] = c;
  return r;
endfunction

function automatic logic [31:0] normalize_pack(input logic sign, input logic [7:0] exp_in,
                                               input logic sub, input logic [26:0] sum);
  logic [25:0] sig;
  int          e;
  int          lz;
  e   = exp_in;
  sig = sum[25:0];
  if (!sub) begin
    if (sum[26]) begin
      sig = sum[26:1];
      e   = e + 1;
    end
  end else begin
    lz = 0;
    while (lz < 26 && !sig[25-lz]) begin
      lz++;
    end
    // cancellation and underflow both give +0
    if (lz == 26 || e <= lz) begin
      return 32'h0000_0000;
    end
    sig = sig << lz;
    e   = e - lz;
  end
  if (e >= 255) begin
    return {sign, 8'hff, 23'd0};
  end
  return {sign, 8'(e), sig[24:2]};
endfunction

function automatic logic [31:0] expected_fp_add(input logic [31:0] a, input logic [31:0] b,
                                                input logic sub, input int lpl);
  logic        a_big;
  int          shift;
  logic [25:0] sig_big;
  logic [25:0] sig_small;
  logic        eff_sub;
  logic        sign;
  a_big     = a[30:0] >= b[30:0];
  shift     = int'(a[30:23]) - int'(b[30:23]);
  sig_big   = a_big ? working_significand(a) : working_significand(b);
  sig_small = a_big ? working_significand(b) : working_significand(a);
  if (!a_big) begin
    shift = -shift;
  end
  sig_small = (shift >= 26) ? 26'd0 : (sig_small >> shift);
  eff_sub   = a[31] ^ b[31] ^ sub;
  sign      = a_big ? a[31] : (b[31] ^ sub);
  return normalize_pack(sign, a_big ? a[30:23] : b[30:23], eff_sub,
                        loa_sig_sum(sig_big, sig_small, eff_sub, lpl));
endfunction

`endif

/* tests/tb_approx_fp_adder.sv */
`default_nettype none

module tb_approx_fp_adder
  import approx_fp_pkg::*;
#(
  parameter int LPL = 8
);

  timeunit 1ns;
  timeprecision 1ps;

  // the tests take about 3100 cycles, mostly the gapped random phase
  localparam int MAX_CYCLES = 6000;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        op_sub;
  logic        out_valid;
  logic [31:0] result;

  logic [31:0] exp_q[$];
  int          issue_q[$];
  int          cycle = 0;

  `include "fp_model.svh"

  approx_fp_adder #(
    .LPL (LPL)
  ) approx_fp_adder_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .op_sub    (op_sub),
    .out_valid (out_valid),
    .result    (result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    assert (cycle < MAX_CYCLES)
      else fail_run($sformatf("timeout, the run was still going after %0d cycles", MAX_CYCLES));
  end

  // sampled on the falling edge, where strobes and results are settled
  always @(negedge clk) begin : monitor
    logic [31:0] want;
    int          born;
    if (rst_n && in_valid) begin
      issue_q.push_back(cycle);
    end
    if (rst_n && out_valid) begin
      assert (exp_q.size() != 0)
        else fail_run("an output arrived while no result was expected");
      want = exp_q.pop_front();
      born = issue_q.pop_front();
      assert (cycle - born == 3)
        else fail_run($sformatf("** Error at time %0t: result came %0d cycles after its strobe",
                                $time, cycle - born));
      assert (result === want)
        else fail_run($sformatf("** Error at time %0t: result %08h, expected %08h",
                                $time, result, want));
    end
  end

  task automatic issue(input logic [31:0] a, input logic [31:0] b, input logic sub);
    @(posedge clk);
    in_valid <= 1'b1;
    op_a     <= a;
    op_b     <= b;
    op_sub   <= sub;
    exp_q.push_back(expected_fp_add(a, b, sub, LPL));
  endtask

  task automatic pause(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // hand-checked values, some of them hold only on the exact path
  task automatic issue_known(input logic [31:0] a, input logic [31:0] b, input logic sub,
                             input logic [31:0] want, input bit exact_only);
    logic [31:0] got;
    got = expected_fp_add(a, b, sub, LPL);
    if (!exact_only || LPL == 0) begin
      assert (got == want)
        else fail_run($sformatf(
          "** Error at time %0t: model gives %08h for %08h and %08h, not %08h",
          $time, got, a, b, want));
    end
    issue(a, b, sub);
  endtask

  function automatic logic [31:0] rand_operand(input int base_exp);
    fp32_u u;
    int    e;
    e = base_exp + int'($urandom_range(0, 6)) - 3;
    if ($urandom_range(0, 31) == 0) begin
      e = 0;
    end
    e = (e < 0) ? 0 : ((e > 254) ? 254 : e);
    u.f.sign = 1'($urandom_range(0, 1));
    u.f.exp  = 8'(e);
    u.f.frac = 23'($urandom);
    return u.raw;
  endfunction

  task automatic check_idle();
    repeat (10) begin
      @(negedge clk);
      assert (out_valid === 1'b0)
        else fail_run($sformatf("** Error at time %0t: out_valid high with no strobe", $time));
    end
  endtask

  task automatic exact_adds();
    issue_known(32'h3f80_0000, 32'h4000_0000, 1'b0, 32'h4040_0000, 1'b0);
    issue_known(32'h4060_0000, 32'h3e80_0000, 1'b0, 32'h4070_0000, 1'b0);
    issue_known(32'h3fc0_0000, 32'h4020_0000, 1'b0, 32'h4080_0000, 1'b0);
    issue_known(32'h4120_0000, 32'h40c0_0000, 1'b0, 32'h4180_0000, 1'b0);
    issue_known(32'hbf80_0000, 32'hc000_0000, 1'b0, 32'hc040_0000, 1'b0);
    issue_known(32'h4060_0000, 32'hbe80_0000, 1'b1, 32'h4070_0000, 1'b0);
    pause(4);
  endtask

  task automatic back_to_back();
    for (int i = 0; i < 20; i++) begin
      issue(rand_operand(EXP_BIAS), rand_operand(EXP_BIAS), 1'($urandom_range(0, 1)));
    end
    pause(5);
  endtask

  task automatic subtractions();
    issue_known(32'h3fc0_0000, 32'h3fc0_0000, 1'b1, 32'h0000_0000, 1'b1);
    issue_known(32'h3f80_0001, 32'h3f80_0000, 1'b1, 32'h3400_0000, 1'b1);
    issue_known(32'h40a0_0000, 32'hc040_0000, 1'b0, 32'h4000_0000, 1'b1);
    issue_known(32'h3f80_0000, 32'h4040_0000, 1'b1, 32'hc000_0000, 1'b1);
    issue_known(32'h4b80_0000, 32'h3a80_0000, 1'b1, 32'h4b80_0000, 1'b1);
    issue_known(32'h4b80_0000, 32'h3a80_0000, 1'b0, 32'h4b80_0000, 1'b0);
    pause(4);
  endtask

  task automatic exponent_edges();
    issue_known(32'h0040_0000, 32'h4000_0000, 1'b0, 32'h4000_0000, 1'b0);
    issue_known(32'h0000_0000, 32'h3f80_0000, 1'b0, 32'h3f80_0000, 1'b0);
    issue_known(32'h7f00_0000, 32'h7f00_0000, 1'b0, 32'h7f80_0000, 1'b0);
    issue_known(32'hff00_0000, 32'hff00_0000, 1'b0, 32'hff80_0000, 1'b0);
    issue_known(32'h0080_0001, 32'h0080_0000, 1'b1, 32'h0000_0000, 1'b1);
    issue_known(32'h0080_0000, 32'h00c0_0000, 1'b1, 32'h0000_0000, 1'b1);
    pause(4);
  endtask

  task automatic random_ops();
    int base_a;
    int base_b;
    for (int i = 0; i < 2000; i++) begin
      base_a = $urandom_range(1, 254);
      // mostly close exponents, so cancellation shows up often
      base_b = ($urandom_range(0, 7) == 0) ? int'($urandom_range(1, 254)) : base_a;
      issue(rand_operand(base_a), rand_operand(base_b), 1'($urandom_range(0, 1)));
      if ($urandom_range(0, 3) == 0) begin
        pause($urandom_range(1, 3));
      end
    end
    pause(5);
  endtask

  initial begin
    rst_n    = 1'b0;
    in_valid = 1'b0;
    op_a     = '0;
    op_b     = '0;
    op_sub   = 1'b0;
    void'($urandom(24535));
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    check_idle();
    exact_adds();
    back_to_back();
    subtractions();
    exponent_edges();
    random_ops();
    repeat (10) @(posedge clk);
    assert (exp_q.size() == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_run($sformatf("%0d expected results never came out", exp_q.size()));
    end
  end

endmodule

`default_nettype wire

/* approx_fp_adder.f */
+incdir+tests
hw/approx_fp_pkg.sv
hw/loa_adder.sv
hw/significand_adder.sv
hw/fp_align.sv
hw/fp_normalize.sv
hw/approx_fp_adder.sv
tests/tb_approx_fp_adder.sv

/* Makefile */
# number of OR-approximated bits, 0 selects the exact significand path
LPL ?= 8

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -GLPL=$(LPL) \
		--top-module tb_approx_fp_adder -f approx_fp_adder.f

run: compile
	./obj_dir/Vtb_approx_fp_adder

clean:
	rm -rf obj_dir
